// ==== hdl/matmul_pkg.sv ====
`default_nettype none

// shared widths and types for the weight by activation accumulator
package matmul_pkg;

    // one packed weight byte carries a base-5 digit and two base-7 digits,
    // so there is one accumulator row per digit
    localparam int NUM_ROWS = 3;

    // signed activation width
    localparam int ACT_W = 8;

    // accumulator width
    // wide enough for long batches of doubled int8 values
    localparam int ACC_W = 18;

    // signed activation as it arrives each cycle
    typedef logic signed [ACT_W-1:0] act_t;

    // activation after sign extension and optional doubling or halving
    typedef logic signed [ACT_W:0] addend_t;

    // one row's running sum
    typedef logic signed [ACC_W-1:0] acc_t;

    // one decoded weight
    // zero makes the row hold its sum
    // sign subtracts the scaled activation
    // mul2 doubles the activation
    // div2 halves the activation and rounds toward minus infinity
    typedef struct packed {
        logic zero;
        logic sign;
        logic mul2;
        logic div2;
    } weight_ctrl_t;

    // decoded weights of one packed byte, indexed by row
    typedef weight_ctrl_t [NUM_ROWS-1:0] weight_set_t;

    // everything the rows consume in one cycle
    typedef struct packed {
        weight_set_t weights;
        act_t        act;
    } operand_t;

endpackage

`default_nettype wire

// ==== hdl/weight_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

// splits a packed weight byte into one base-5 and two base-7 digits
// and turns each digit into the per-row control flags
module weight_decoder
    import matmul_pkg::*;
(
    input  wire [7:0]  weights,
    output weight_set_t weight_set
);

    // only 5 * 7 * 7 = 245 codes are valid and the rest mean no weight at all
    localparam logic [7:0] CODE_LIMIT = 8'd245;

    // flags are ordered {zero, sign, mul2, div2}
    localparam weight_ctrl_t ZERO_WEIGHT = 4'b1000;

    logic [7:0] quot5;
    logic [2:0] digit_q;
    logic [2:0] digit_s1;
    logic [2:0] digit_s0;

    // base-5 digit to weight 0, 1, 2, -1 or -2
    function automatic weight_ctrl_t decode_quinary(input logic [2:0] digit);
        weight_ctrl_t ctrl;
        case (digit)
            3'd0:    ctrl = 4'b1000;
            3'd1:    ctrl = 4'b0000;
            3'd2:    ctrl = 4'b0010;
            3'd3:    ctrl = 4'b0100;
            3'd4:    ctrl = 4'b0110;
            default: ctrl = ZERO_WEIGHT;
        endcase
        return ctrl;
    endfunction

    // base-7 digit to weight 0, 1/2, 1, 2, -1/2, -1 or -2
    function automatic weight_ctrl_t decode_septenary(input logic [2:0] digit);
        weight_ctrl_t ctrl;
        case (digit)
            3'd0:    ctrl = 4'b1000;
            3'd1:    ctrl = 4'b0001;  // +1/2
            3'd2:    ctrl = 4'b0000;
            3'd3:    ctrl = 4'b0010;
            3'd4:    ctrl = 4'b0101;  // -1/2
            3'd5:    ctrl = 4'b0100;
            3'd6:    ctrl = 4'b0110;
            default: ctrl = ZERO_WEIGHT;
        endcase
        return ctrl;
    endfunction

    // the code is d0 * 35 + d1 * 5 + dq
    always_comb begin
        quot5    = weights / 8'd5;
        digit_q  = 3'(weights % 8'd5);
        digit_s1 = 3'(quot5 % 8'd7);
        digit_s0 = 3'(quot5 / 8'd7);
    end

    // lowest digit drives the highest row, as in the packed format
    always_comb begin
        if (weights < CODE_LIMIT) begin
            weight_set[2] = decode_quinary(digit_q);
            weight_set[1] = decode_septenary(digit_s1);
            weight_set[0] = decode_septenary(digit_s0);
        end else begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                weight_set[r] = ZERO_WEIGHT;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mac_array.sv ====
`timescale 1ns/1ps
`default_nettype none

// operand double buffer followed by one scaling accumulator per row
//
// an operand sampled at edge k sits in the next stage after k, in the
// current stage after k+1, and lands in the accumulator at k+2
module mac_array
    import matmul_pkg::*;
(
    input  wire       clk,
    input  wire       reset,
    input  wire       operand_t operand,
    input  wire       readout,
    output acc_t      acc_next [NUM_ROWS]
);

    operand_t operand_next;
    operand_t operand_curr;

    acc_t    acc [NUM_ROWS];
    addend_t act_ext;
    addend_t addend [NUM_ROWS];

    // input side of the double buffer
    always_ff @(posedge clk) begin
        if (reset) begin
            operand_next <= '0;
        end else begin
            operand_next <= operand;
        end
    end

    // current stage that the rows compute on
    always_ff @(posedge clk) begin
        if (reset) begin
            operand_curr <= '0;
        end else begin
            operand_curr <= operand_next;
        end
    end

    // sign extend before any shift so halving stays arithmetic
    assign act_ext = {operand_curr.act[ACT_W-1], operand_curr.act};

    // per-row scaling of the shared activation
    always_comb begin
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (operand_curr.weights[r].mul2) begin
                addend[r] = act_ext <<< 1;
            end else if (operand_curr.weights[r].div2) begin
                // floor division so -3 / 2 gives -2
                addend[r] = act_ext >>> 1;
            end else begin
                addend[r] = act_ext;
            end
        end
    end

    // next sum of every row
    always_comb begin
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (operand_curr.weights[r].zero) begin
                acc_next[r] = acc[r];
            end else if (operand_curr.weights[r].sign) begin
                acc_next[r] = acc[r] - acc_t'(addend[r]);
            end else begin
                acc_next[r] = acc[r] + acc_t'(addend[r]);
            end
        end
    end

    // readout clears the sums in the same edge that the queue takes acc_next,
    // so the operand already in the next stage opens the new batch
    always_ff @(posedge clk) begin
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (reset || readout) begin
                acc[r] <= '0;
            end else begin
                acc[r] <= acc_next[r];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/readout_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

// output queue of row sums
// loaded all at once on readout, then drained one row per cycle
module readout_queue
    import matmul_pkg::*;
#(
    // lowest sum bit that appears on out
    parameter int OUT_SHIFT = 9
) (
    input  wire        clk,
    input  wire        reset,
    input  wire        readout,
    input  wire  acc_t acc_next [NUM_ROWS],
    output logic [7:0] out
);

    acc_t queue [NUM_ROWS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                queue[r] <= '0;
            end
        end else if (readout) begin
            // acc_next already holds the operand in the current stage
            for (int r = 0; r < NUM_ROWS; r++) begin
                queue[r] <= acc_next[r];
            end
        end else begin
            // shift toward entry 0
            // top entry keeps its value so the last row stays on out
            for (int r = 0; r < NUM_ROWS - 1; r++) begin
                queue[r] <= queue[r+1];
            end
        end
    end

    // byte window of the head entry
    assign out = queue[0][OUT_SHIFT +: 8];

endmodule

`default_nettype wire

// ==== hdl/matmul_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// weight by activation accumulator
//
// each cycle one packed weight byte and one int8 activation are taken in,
// a readout pulse dumps the three row sums and restarts accumulation
module matmul_top
    import matmul_pkg::*;
#(
    parameter int OUT_SHIFT = 9
) (
    input  wire        clk,
    input  wire        reset,
    input  wire  [7:0] weights,
    input  wire  act_t act,
    input  wire        readout,
    output logic [7:0] out
);

    weight_set_t weight_set;
    operand_t    operand;
    acc_t        acc_next [NUM_ROWS];

    // combinational decode of the byte code into per-row flags
    weight_decoder u_weight_decoder (
        .weights    (weights),
        .weight_set (weight_set)
    );

    // weights and activation travel together through the mac pipeline
    assign operand.weights = weight_set;
    assign operand.act     = act;

    mac_array u_mac_array (
        .clk      (clk),
        .reset    (reset),
        .operand  (operand),
        .readout  (readout),
        .acc_next (acc_next)
    );

    readout_queue #(
        .OUT_SHIFT (OUT_SHIFT)
    ) u_readout_queue (
        .clk      (clk),
        .reset    (reset),
        .readout  (readout),
        .acc_next (acc_next),
        .out      (out)
    );

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

// free running testbench clock and a synchronous reset pulse
module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset drops on a falling edge, like the other DUT inputs
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== dv/matmul_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

// testbench for the weight by activation accumulator
module matmul_tb
    import matmul_pkg::*;
();

    localparam int OUT_SHIFT    = 2;
    localparam int RESET_CYCLES = 8;
    localparam int RESET_CHECKS = 6;

    // digit weights doubled so that halves stay integer
    localparam int QUIN_X2 [5] = '{0, 2, 4, -2, -4};
    localparam int SEPT_X2 [7] = '{0, 1, 2, 4, -1, -2, -4};

    logic       clk;
    logic       reset;
    logic [7:0] weights;
    act_t       act;
    logic       readout;
    logic [7:0] out;

    // the pairs of a batch sit at first .. first+count-1 of the pair queues
    string batch_name [$];
    int    batch_first [$];
    int    batch_count [$];
    int    batch_rand [$];
    int    batch_gap [$];
    int    pair_code [$];
    int    pair_act [$];

    // inputs as sampled at each rising edge
    int code_log [$];
    int act_log [$];

    // bytes still to be compared in order of the edge they follow
    int         pend_due [$];
    int         pend_test [$];
    int         pend_row [$];
    logic [7:0] pend_exp [$];

    // last row byte that out keeps until the next readout
    bit         hold_valid;
    logic [7:0] hold_exp;

    string test_name [$];
    int    test_errs [$];

    logic [31:0] rng_state = 32'h9b91_4237;
    int          next_edge;
    int          batch_start;
    int          cur_test;
    int          tests_passed;
    int          tests_failed;
    int          timeout_cycles;
    bit          table_ready;

    tb_clock_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    matmul_top #(
        .OUT_SHIFT (OUT_SHIFT)
    ) dut (
        .clk     (clk),
        .reset   (reset),
        .weights (weights),
        .act     (act),
        .readout (readout),
        .out     (out)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // row 2 takes code mod 5, row 1 takes code / 5 mod 7, row 0 takes code / 35
    function automatic int weight_x2(input int code, input int row);
        if (code >= 245) return 0;
        case (row)
            0:       return SEPT_X2[code / 35];
            1:       return SEPT_X2[(code / 5) % 7];
            default: return QUIN_X2[code % 5];
        endcase
    endfunction

    // floor of a / 2
    function automatic int floor_half(input int a);
        if (a >= 0) return a / 2;
        return -((1 - a) / 2);
    endfunction

    function automatic int row_contrib(input int code, input int row, input int a);
        int w2;
        w2 = weight_x2(code, row);
        if (w2 == 1) return floor_half(a);
        if (w2 == -1) return -floor_half(a);
        return (w2 / 2) * a;
    endfunction

    task automatic add_pair(input int code, input int a);
        pair_code.push_back(code);
        pair_act.push_back(a);
    endtask

    // closes a batch over the pairs added since the previous one
    task automatic add_batch(input string name, input int n_rand, input int gap);
        int first;
        first = 0;
        if (batch_first.size() > 0) first = batch_first[$] + batch_count[$];
        batch_name.push_back(name);
        batch_first.push_back(first);
        batch_count.push_back(pair_code.size() - first);
        batch_rand.push_back(n_rand);
        batch_gap.push_back(gap);
    endtask

    task automatic build_table();
        // one input per batch for every nonzero digit of every row
        for (int c = 1; c <= 4; c++) begin
            add_pair(c, 84);
            add_batch($sformatf("single_%0d", c), 0, 2);
        end
        for (int c = 5; c <= 30; c += 5) begin
            add_pair(c, 101);
            add_batch($sformatf("single_%0d", c), 0, 2);
        end
        for (int c = 35; c <= 210; c += 35) begin
            add_pair(c, 117);
            add_batch($sformatf("single_%0d", c), 0, 2);
        end
        // code 58 is +1/2 -1/2 -1, code 146 is -1/2 +1/2 +1
        repeat (8) add_pair(58, -3);
        add_batch("half_neg_odd", 0, 2);
        for (int i = 0; i < 10; i++) begin
            add_pair((i % 2) ? 146 : 58, 2 * i - 11);
        end
        add_batch("half_mixed", 0, 2);
        // one real weight first, then codes past the table must hold the sums
        add_pair(124, 90);
        for (int c = 245; c <= 255; c++) begin
            add_pair(c, c - 250);
        end
        add_batch("invalid_codes", 0, 2);
        add_batch("random_a", 40, 2);
        add_batch("random_b", 40, 2);
        add_batch("random_c", 40, 2);
        // last input of a gap-0 batch is sampled one edge before readout
        add_pair(2, 50);
        add_pair(2, 60);
        add_batch("b2b_first", 0, 0);
        add_pair(10, -40);
        add_pair(10, 33);
        add_batch("b2b_second", 0, 0);
        add_batch("b2b_third", 20, 1);
        add_pair(70, 25);
        add_batch("b2b_last", 0, 2);

        timeout_cycles = RESET_CYCLES + RESET_CHECKS + 64;
        for (int b = 0; b < batch_name.size(); b++) begin
            timeout_cycles += batch_count[b] + batch_rand[b] + batch_gap[b] + 1;
        end
    endtask

    task automatic random_pair(output int code, output int a);
        act_t ra;
        rng_state = lcg_next(rng_state);
        // about one code in eight lands past the table
        if (rng_state[15:13] == 3'd0) begin
            code = 245 + int'(rng_state[31:24] % 8'd11);
        end else begin
            code = int'(rng_state[31:24]);
        end
        ra = act_t'(rng_state[23:16]);
        a = int'(ra);
    endtask

    task automatic open_test(input string name, output int t);
        t = test_name.size();
        test_name.push_back(name);
        test_errs.push_back(0);
    endtask

    task automatic report_test(input int t);
        if (test_errs[t] == 0) begin
            tests_passed++;
            $display("test %s passed", test_name[t]);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d wrong bytes", test_name[t], test_errs[t]);
        end
    endtask

    // one cycle of inputs, then compare whatever is due by the next falling edge
    task automatic step_cycle(input int code, input int a, input bit rd);
        int               t;
        int               sum;
        bit               checked;
        logic [ACC_W-1:0] wrapped;
        weights = 8'(code);
        act = act_t'(a);
        readout = rd;
        code_log.push_back(code);
        act_log.push_back(a);
        if (rd) begin
            // a readout at edge m takes the inputs before edge m-1
            for (int r = 0; r < NUM_ROWS; r++) begin
                sum = 0;
                for (int e = batch_start; e <= next_edge - 2; e++) begin
                    sum += row_contrib(code_log[e], r, act_log[e]);
                end
                wrapped = ACC_W'(sum);
                pend_due.push_back(next_edge + r);
                pend_test.push_back(cur_test);
                pend_row.push_back(r);
                pend_exp.push_back(wrapped[OUT_SHIFT +: 8]);
            end
            batch_start = next_edge - 1;
        end
        next_edge++;
        @(negedge clk);
        checked = 1'b0;
        while (pend_due.size() > 0 && pend_due[0] == next_edge - 1) begin
            t = pend_test[0];
            checked = 1'b1;
            assert (out == pend_exp[0]) else begin
                $display("MISMATCH %s row %0d: expected 0x%02h, actual 0x%02h",
                         test_name[t], pend_row[0], pend_exp[0], out);
                test_errs[t] = test_errs[t] + 1;
            end
            if (pend_row[0] == NUM_ROWS - 1) begin
                hold_exp = pend_exp[0];
                hold_valid = 1'b1;
                report_test(t);
            end
            void'(pend_due.pop_front());
            void'(pend_test.pop_front());
            void'(pend_row.pop_front());
            void'(pend_exp.pop_front());
        end
        // the last row stays on out until the next readout
        if (hold_valid && !checked) begin
            assert (out == hold_exp) else begin
                $display("MISMATCH %s held row %0d: expected 0x%02h, actual 0x%02h",
                         test_name[cur_test], NUM_ROWS - 1, hold_exp, out);
                test_errs[cur_test] = test_errs[cur_test] + 1;
            end
        end
    endtask

    task automatic check_reset_idle();
        int t;
        open_test("reset_idle", t);
        for (int i = 0; i < RESET_CHECKS; i++) begin
            @(negedge clk);
            assert (out == 8'h00) else begin
                $display("MISMATCH %s: expected 0x00, actual 0x%02h", test_name[t], out);
                test_errs[t] = test_errs[t] + 1;
            end
        end
        report_test(t);
    endtask

    // watchdog
    initial begin
        wait (table_ready);
        repeat (timeout_cycles) @(posedge clk);
        $display("simulation timed out after %0d cycles, test table did not finish",
                 timeout_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int rc;
        int ra;
        weights = 8'h00;
        act = '0;
        readout = 1'b0;
        next_edge = 0;
        batch_start = 0;
        cur_test = 0;
        tests_passed = 0;
        tests_failed = 0;
        hold_valid = 1'b0;
        hold_exp = 8'h00;
        build_table();
        table_ready = 1'b1;
        @(negedge reset);
        check_reset_idle();

        for (int b = 0; b < batch_name.size(); b++) begin
            open_test(batch_name[b], cur_test);
            for (int i = 0; i < batch_count[b]; i++) begin
                step_cycle(pair_code[batch_first[b] + i], pair_act[batch_first[b] + i], 1'b0);
            end
            for (int i = 0; i < batch_rand[b]; i++) begin
                random_pair(rc, ra);
                step_cycle(rc, ra, 1'b0);
            end
            repeat (batch_gap[b]) step_cycle(0, 0, 1'b0);
            step_cycle(0, 0, 1'b1);
        end
        // drain the last queue
        while (pend_due.size() > 0) step_cycle(0, 0, 1'b0);

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/matmul_pkg.sv
hdl/weight_decoder.sv
hdl/mac_array.sv
hdl/readout_queue.sv
hdl/matmul_top.sv
dv/tb_clock_gen.sv
dv/matmul_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := matmul_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the pass line in the simulator output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf $(OBJ_DIR)
